//--- rtl/imm_extract.svh
`ifndef IMM_EXTRACT_SVH
`define IMM_EXTRACT_SVH

// data immediate, inst[4:0] and inst[31:25] never take part
function automatic logic [31:0] inst_to_data_imm(
    input logic [31:0]           inst,
    input decode_pkg::imm_type_t imm_type
);
    logic [31:0] imm;
    case (imm_type)
        decode_pkg::IMM_S12: imm = {{20{inst[21]}}, inst[21:10]};
        decode_pkg::IMM_S20: imm = {{12{inst[24]}}, inst[24:5]};   // lu12i.w, shifted in ALU
        decode_pkg::IMM_U5:  imm = {27'b0, inst[14:10]};           // shift amount
        default:             imm = {20'b0, inst[21:10]};           // u12 logical ops
    endcase
    return imm;
endfunction

// address immediate for load/store offsets and branch targets
function automatic logic [31:0] inst_to_addr_imm(
    input logic [31:0]                inst,
    input decode_pkg::addr_imm_type_t addr_imm_type
);
    logic [31:0] imm;
    case (addr_imm_type)
        decode_pkg::ADDR_S12: imm = {{20{inst[21]}}, inst[21:10]};
        decode_pkg::ADDR_S16: imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        // s26 keeps its upper ten bits in inst[9:0]
        default:              imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    endcase
    return imm;
endfunction

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

    localparam int ISSUE_WIDTH = 2;                          // slots per fetch packet
    localparam int QUEUE_DEPTH = 2;                          // fetch queue entries
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
    localparam int REG_ID_W    = 5;                          // 32 architectural GPRs
    localparam int EXC_W       = 4;                          // fetch exception code

    localparam logic [1:0] MSIZE_WORD = 2'd2;                // byte=0, half=1, word=2

    // read-register source, anything but zero counts as a register need
    typedef enum logic [2:0] {
        REG_ZERO = 3'd0,
        REG_RD   = 3'd1,
        REG_RJ   = 3'd2,
        REG_RK   = 3'd3,
        REG_IMM  = 3'd4
    } reg_sel_t;

    typedef enum logic [1:0] {
        WREG_NONE = 2'd0,
        WREG_RD   = 2'd1,
        WREG_RJ   = 2'd2,
        WREG_R1   = 2'd3   // link register, bl only
    } wreg_sel_t;

    typedef enum logic [1:0] {
        IMM_S12 = 2'd0,
        IMM_S20 = 2'd1,    // inst[24:5]
        IMM_U5  = 2'd2,
        IMM_U12 = 2'd3
    } imm_type_t;

    typedef enum logic [1:0] {
        ADDR_S12 = 2'd0,   // load/store offset, no shift
        ADDR_S16 = 2'd1,   // conditional branch and jirl, <<2
        ADDR_S26 = 2'd2    // bl, <<2
    } addr_imm_type_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_LUI  = 4'd7,
        ALU_MUL  = 4'd8,
        ALU_NONE = 4'd9
    } alu_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MDU    = 2'd1,
        UNIT_LSU    = 2'd2,
        UNIT_BRANCH = 2'd3
    } unit_t;

    typedef struct packed {
        logic [31:0]                              pc;            // 8-byte aligned
        logic [ISSUE_WIDTH-1:0]                   mask;
        logic [ISSUE_WIDTH-1:0][31:0]             insts;
        logic [ISSUE_WIDTH-1:0]                   predict_taken;
        logic [ISSUE_WIDTH-1:0][EXC_W-1:0]        fetch_exc;
    } fetch_pkt_t;

    // per-slot result of basic_decoder
    typedef struct packed {
        logic [31:0]    inst;
        reg_sel_t       r0;
        reg_sel_t       r1;
        wreg_sel_t      w;
        imm_type_t      imm_type;
        addr_imm_type_t addr_imm_type;
        alu_op_t        alu_op;
        unit_t          unit;
        logic           mem_write;
        logic [1:0]     mem_size;
        logic           mem_signed;
        logic           break_inst;
        logic           syscall_inst;
        logic           decode_err;
    } decode_info_t;

    typedef struct packed {
        logic [ISSUE_WIDTH-1:0]                   r_valid;
        logic [ISSUE_WIDTH-1:0][31:0]             pc;
        logic [2*ISSUE_WIDTH-1:0][REG_ID_W-1:0]   r_arfid;       // two reads per slot
        logic [ISSUE_WIDTH-1:0][REG_ID_W-1:0]     w_arfid;
        logic [2*ISSUE_WIDTH-1:0]                 reg_need;
        logic [2*ISSUE_WIDTH-1:0]                 use_imm;
        logic [ISSUE_WIDTH-1:0]                   w_reg;
        logic [ISSUE_WIDTH-1:0]                   w_mem;
        logic [ISSUE_WIDTH-1:0][31:0]             data_imm;
        logic [ISSUE_WIDTH-1:0][31:0]             addr_imm;
        alu_op_t [ISSUE_WIDTH-1:0]                op;
        unit_t [ISSUE_WIDTH-1:0]                  unit;
        logic [ISSUE_WIDTH-1:0][1:0]              msize;
        logic [ISSUE_WIDTH-1:0]                   msigned;
        logic [ISSUE_WIDTH-1:0]                   break_inst;
        logic [ISSUE_WIDTH-1:0]                   syscall_inst;
        logic [ISSUE_WIDTH-1:0]                   is_branch;
        logic [ISSUE_WIDTH-1:0]                   decode_err;
        logic [ISSUE_WIDTH-1:0]                   predict_taken;
        logic [ISSUE_WIDTH-1:0][EXC_W-1:0]        fetch_exc;
    } rename_pkt_t;

endpackage

//--- rtl/basic_decoder.sv
`timescale 1ns/10ps

module basic_decoder (
    input  logic [31:0]              inst,
    output decode_pkg::decode_info_t info
);

    import decode_pkg::*;

    always_comb begin
        // defaults describe an instruction with no operands and no side effects
        info               = '0;
        info.inst          = inst;
        info.r0            = REG_ZERO;
        info.r1            = REG_ZERO;
        info.w             = WREG_NONE;
        info.imm_type      = IMM_U12;
        info.addr_imm_type = ADDR_S12;
        info.alu_op        = ALU_NONE;
        info.unit          = UNIT_ALU;

        casez (inst[31:15])
            // three-register group, minor opcode sits in inst[19:15]
            17'b00000000000100000, 17'b00000000000100010, 17'b00000000000100100,
            17'b00000000000101001, 17'b00000000000101010, 17'b00000000000101011,
            17'b00000000000111000: begin
                info.r0 = REG_RJ;
                info.r1 = REG_RK;
                info.w  = WREG_RD;
                case (inst[19:15])
                    5'b00000: info.alu_op = ALU_ADD;
                    5'b00010: info.alu_op = ALU_SUB;
                    5'b00100: info.alu_op = ALU_SLT;
                    5'b01001: info.alu_op = ALU_AND;
                    5'b01010: info.alu_op = ALU_OR;
                    5'b01011: info.alu_op = ALU_XOR;
                    default: begin  // mul.w
                        info.alu_op = ALU_MUL;
                        info.unit   = UNIT_MDU;
                    end
                endcase
            end
            17'b00000000001010100: info.break_inst   = 1'b1;
            17'b00000000001010110: info.syscall_inst = 1'b1;
            17'b00000000010000001: begin  // slli.w
                info.r0       = REG_RJ;
                info.r1       = REG_IMM;
                info.w        = WREG_RD;
                info.imm_type = IMM_U5;
                info.alu_op   = ALU_SLL;
            end
            17'b0000001010???????: begin  // addi.w
                info.r0       = REG_RJ;
                info.r1       = REG_IMM;
                info.w        = WREG_RD;
                info.imm_type = IMM_S12;
                info.alu_op   = ALU_ADD;
            end
            17'b0000001110???????: begin  // ori
                info.r0       = REG_RJ;
                info.r1       = REG_IMM;
                info.w        = WREG_RD;
                info.imm_type = IMM_U12;
                info.alu_op   = ALU_OR;
            end
            17'b0001010??????????: begin  // lu12i.w
                info.r0       = REG_IMM;
                info.w        = WREG_RD;
                info.imm_type = IMM_S20;
                info.alu_op   = ALU_LUI;
            end
            17'b0010100010???????: begin  // ld.w
                info.r0         = REG_RJ;
                info.w          = WREG_RD;
                info.alu_op     = ALU_ADD;  // base + offset
                info.unit       = UNIT_LSU;
                info.mem_size   = MSIZE_WORD;
                info.mem_signed = 1'b1;
            end
            17'b0010100110???????: begin  // st.w, rd holds the store data
                info.r0        = REG_RJ;
                info.r1        = REG_RD;
                info.alu_op    = ALU_ADD;
                info.unit      = UNIT_LSU;
                info.mem_write = 1'b1;
                info.mem_size  = MSIZE_WORD;
            end
            17'b010011???????????: begin  // jirl
                info.r0            = REG_RJ;
                info.w             = WREG_RD;
                info.addr_imm_type = ADDR_S16;
                info.unit          = UNIT_BRANCH;
            end
            17'b010101???????????: begin  // bl
                info.w             = WREG_R1;
                info.addr_imm_type = ADDR_S26;
                info.unit          = UNIT_BRANCH;
            end
            17'b010110???????????, 17'b010111???????????: begin  // beq, bne
                info.r0            = REG_RJ;
                info.r1            = REG_RD;
                info.addr_imm_type = ADDR_S16;
                info.unit          = UNIT_BRANCH;
            end
            default: info.decode_err = 1'b1;  // outside the supported subset
        endcase
    end

endmodule

//--- rtl/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  logic                    head_valid,
    output logic                    head_ready,
    input  decode_pkg::fetch_pkt_t  head_pkt,
    output logic                    out_valid,
    input  logic                    out_ready,
    output decode_pkg::rename_pkt_t out_pkt
);

    import decode_pkg::*;

`include "imm_extract.svh"

    decode_info_t infos [ISSUE_WIDTH];

    function automatic logic [REG_ID_W-1:0] read_id(
        input logic [31:0] inst,
        input reg_sel_t    sel
    );
        case (sel)
            REG_RD:  return inst[4:0];
            REG_RJ:  return inst[9:5];
            REG_RK:  return inst[14:10];
            default: return '0;  // zero and immediate both read r0
        endcase
    endfunction

    function automatic logic [REG_ID_W-1:0] write_id(
        input logic [31:0] inst,
        input wreg_sel_t   sel
    );
        case (sel)
            WREG_RD: return inst[4:0];
            WREG_RJ: return inst[9:5];
            WREG_R1: return REG_ID_W'(1);
            default: return '0;  // no write lands on r0
        endcase
    endfunction

    // purely combinational, so the handshake goes straight through
    assign out_valid  = head_valid;
    assign head_ready = out_ready;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
        basic_decoder u_basic_decoder (
            .inst (head_pkt.insts[i]),
            .info (infos[i])
        );
    end

    always_comb begin
        out_pkt.r_valid       = head_pkt.mask;
        out_pkt.predict_taken = head_pkt.predict_taken;
        out_pkt.fetch_exc     = head_pkt.fetch_exc;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            out_pkt.pc[i] = head_pkt.pc | 32'(i * 4);  // slot 1 sets bit 2

            out_pkt.r_arfid[2*i]   = read_id(infos[i].inst, infos[i].r0);
            out_pkt.r_arfid[2*i+1] = read_id(infos[i].inst, infos[i].r1);
            out_pkt.w_arfid[i]     = write_id(infos[i].inst, infos[i].w);

            out_pkt.reg_need[2*i]   = infos[i].r0 != REG_ZERO;
            out_pkt.reg_need[2*i+1] = infos[i].r1 != REG_ZERO;
            out_pkt.use_imm[2*i]    = infos[i].r0 == REG_IMM;
            out_pkt.use_imm[2*i+1]  = infos[i].r1 == REG_IMM;
            out_pkt.w_reg[i]        = infos[i].w != WREG_NONE;
            out_pkt.w_mem[i]        = infos[i].mem_write;

            out_pkt.data_imm[i] = inst_to_data_imm(infos[i].inst, infos[i].imm_type);
            out_pkt.addr_imm[i] = inst_to_addr_imm(infos[i].inst, infos[i].addr_imm_type);

            out_pkt.op[i]           = infos[i].alu_op;
            out_pkt.unit[i]         = infos[i].unit;
            out_pkt.msize[i]        = infos[i].mem_size;
            out_pkt.msigned[i]      = infos[i].mem_signed;
            out_pkt.break_inst[i]   = infos[i].break_inst;
            out_pkt.syscall_inst[i] = infos[i].syscall_inst;
            out_pkt.is_branch[i]    = infos[i].unit == UNIT_BRANCH;
            out_pkt.decode_err[i]   = infos[i].decode_err;
        end
    end

endmodule

//--- rtl/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::fetch_pkt_t in_pkt,
    output logic                   head_valid,
    input  logic                   head_ready,
    output decode_pkg::fetch_pkt_t head_pkt
);

    import decode_pkg::*;

    fetch_pkt_t        entries [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              push;
    logic              pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
        return (ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ready from the count alone, no path from head_ready
    assign in_ready   = count != QCNT_W'(QUEUE_DEPTH);
    assign head_valid = count != '0;
    assign head_pkt   = entries[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = head_valid & head_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  decode_pkg::fetch_pkt_t  in_pkt,
    output logic                    out_valid,
    input  logic                    out_ready,
    output decode_pkg::rename_pkt_t out_pkt
);

    import decode_pkg::*;

    logic       head_valid;
    logic       head_ready;
    fetch_pkt_t head_pkt;

    // one register stage on entry, decode itself adds no latency
    fetch_queue u_fetch_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pkt     (in_pkt),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_pkt   (head_pkt)
    );

    decoder u_decoder (
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_pkt   (head_pkt),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pkt    (out_pkt)
    );

endmodule

//--- tb/decode_checker.sv
`timescale 1ns/10ps

module decode_checker #(
    parameter int NUM_TESTS = 1
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  decode_pkg::rename_pkt_t out_pkt,
    input  decode_pkg::rename_pkt_t exp_tab [NUM_TESTS],
    output int                      n_checked,
    output int                      n_failed
);

    import decode_pkg::*;

    int held;  // packets inside the stage

    task automatic compare_field(
        input  int          t,
        input  string       name,
        input  logic [63:0] got,
        input  logic [63:0] exp,
        inout  int          bad
    );
        if (got !== exp) begin
            $display("FAIL test %0d %s got %h expected %h", t, name, got, exp);
            bad++;
        end
    endtask

    initial begin
        n_checked = 0;
        n_failed  = 0;
        held      = 0;
    end

    always @(posedge clk) begin
        int          bad;
        rename_pkt_t e;
        bad = 0;
        if (arst_n) begin
            if (in_ready !== (held < 2)) begin
                $display("FAIL in_ready got %h expected %h", in_ready, held < 2);
                n_failed++;
            end
            if (out_valid && out_ready) begin
                if (n_checked >= NUM_TESTS) begin
                    $display("an extra packet came out after the last test");
                    n_failed++;
                end else begin
                    e = exp_tab[n_checked];
                    compare_field(n_checked, "r_valid", 64'(out_pkt.r_valid), 64'(e.r_valid), bad);
                    compare_field(n_checked, "pc", 64'(out_pkt.pc), 64'(e.pc), bad);
                    compare_field(n_checked, "r_arfid", 64'(out_pkt.r_arfid), 64'(e.r_arfid), bad);
                    compare_field(n_checked, "w_arfid", 64'(out_pkt.w_arfid), 64'(e.w_arfid), bad);
                    compare_field(n_checked, "reg_need", 64'(out_pkt.reg_need), 64'(e.reg_need), bad);
                    compare_field(n_checked, "use_imm", 64'(out_pkt.use_imm), 64'(e.use_imm), bad);
                    compare_field(n_checked, "w_reg", 64'(out_pkt.w_reg), 64'(e.w_reg), bad);
                    compare_field(n_checked, "data_imm", 64'(out_pkt.data_imm), 64'(e.data_imm), bad);
                    compare_field(n_checked, "addr_imm", 64'(out_pkt.addr_imm), 64'(e.addr_imm), bad);
                    compare_field(n_checked, "op", 64'(out_pkt.op), 64'(e.op), bad);
                    compare_field(n_checked, "unit", 64'(out_pkt.unit), 64'(e.unit), bad);
                    compare_field(n_checked, "msize", 64'(out_pkt.msize), 64'(e.msize), bad);
                    compare_field(n_checked, "msigned", 64'(out_pkt.msigned), 64'(e.msigned), bad);
                    compare_field(n_checked, "w_mem", 64'(out_pkt.w_mem), 64'(e.w_mem), bad);
                    compare_field(n_checked, "break_inst", 64'(out_pkt.break_inst),
                                  64'(e.break_inst), bad);
                    compare_field(n_checked, "syscall_inst", 64'(out_pkt.syscall_inst),
                                  64'(e.syscall_inst), bad);
                    compare_field(n_checked, "is_branch", 64'(out_pkt.is_branch),
                                  64'(e.is_branch), bad);
                    compare_field(n_checked, "decode_err", 64'(out_pkt.decode_err),
                                  64'(e.decode_err), bad);
                    compare_field(n_checked, "predict_taken", 64'(out_pkt.predict_taken),
                                  64'(e.predict_taken), bad);
                    compare_field(n_checked, "fetch_exc", 64'(out_pkt.fetch_exc),
                                  64'(e.fetch_exc), bad);
                    if (bad == 0) begin
                        $display("PASS test %0d", n_checked);
                    end else begin
                        n_failed++;
                    end
                    n_checked++;
                end
            end
            held = held + int'(in_valid && in_ready) - int'(out_valid && out_ready);
        end
    end

endmodule

//--- tb/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

    import decode_pkg::*;

    localparam int NUM_TESTS = 11;
    localparam int TIMEOUT   = 200;  // cycles per wait

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    fetch_pkt_t  in_pkt;
    logic        out_valid;
    logic        out_ready;
    rename_pkt_t out_pkt;

    fetch_pkt_t  stim [NUM_TESTS];
    rename_pkt_t exp_tab [NUM_TESTS];
    logic [31:0] lfsr;
    int          n_checked;
    int          n_failed;
    bit          timed_out;
    int          waited;

    decode_stage dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    decode_checker #(.NUM_TESTS(NUM_TESTS)) u_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt),
        .exp_tab   (exp_tab),
        .n_checked (n_checked),
        .n_failed  (n_failed)
    );

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic set_pkt(
        input int          t,
        input logic [31:0] pc,
        input logic [1:0]  mask,
        input logic [31:0] i0,
        input logic [31:0] i1,
        input logic [1:0]  pt,
        input logic [7:0]  exc
    );
        stim[t].pc            = pc;
        stim[t].mask          = mask;
        stim[t].insts[0]      = i0;
        stim[t].insts[1]      = i1;
        stim[t].predict_taken = pt;
        stim[t].fetch_exc     = exc;
        exp_tab[t]               = '0;
        exp_tab[t].r_valid       = mask;
        exp_tab[t].pc[0]         = pc;
        exp_tab[t].pc[1]         = pc + 32'd4;
        exp_tab[t].predict_taken = pt;
        exp_tab[t].fetch_exc     = exc;
    endtask

    // need and useimm are {read 1, read 0}
    // flags are {w_reg, branch, msigned, w_mem, break, syscall, err}
    task automatic set_slot(
        input int          t,
        input int          s,
        input logic [4:0]  ra,
        input logic [4:0]  rb,
        input logic [4:0]  wr,
        input logic [1:0]  need,
        input logic [1:0]  useimm,
        input logic [31:0] dimm,
        input logic [31:0] aimm,
        input alu_op_t     op,
        input unit_t       u,
        input logic [6:0]  flags
    );
        exp_tab[t].r_arfid[2*s]    = ra;
        exp_tab[t].r_arfid[2*s+1]  = rb;
        exp_tab[t].w_arfid[s]      = wr;
        exp_tab[t].reg_need[2*s]   = need[0];
        exp_tab[t].reg_need[2*s+1] = need[1];
        exp_tab[t].use_imm[2*s]    = useimm[0];
        exp_tab[t].use_imm[2*s+1]  = useimm[1];
        exp_tab[t].data_imm[s]     = dimm;
        exp_tab[t].addr_imm[s]     = aimm;
        exp_tab[t].op[s]           = op;
        exp_tab[t].unit[s]         = u;
        exp_tab[t].msize[s]        = (u == UNIT_LSU) ? MSIZE_WORD : 2'd0;  // ld.w and st.w only
        exp_tab[t].w_reg[s]        = flags[6];
        exp_tab[t].is_branch[s]    = flags[5];
        exp_tab[t].msigned[s]      = flags[4];
        exp_tab[t].w_mem[s]        = flags[3];
        exp_tab[t].break_inst[s]   = flags[2];
        exp_tab[t].syscall_inst[s] = flags[1];
        exp_tab[t].decode_err[s]   = flags[0];
    endtask

    task automatic fill_table();
        set_pkt(0, 32'h1c000000, 2'b11, 32'h00101483, 32'h001c20e6, 2'b00, 8'h00);  // add.w, mul.w
        set_slot(0, 0, 4, 5, 3, 2'b11, 2'b00, 32'h405, 32'h405, ALU_ADD, UNIT_ALU, 7'b1000000);
        set_slot(0, 1, 7, 8, 6, 2'b11, 2'b00, 32'h708, 32'h708, ALU_MUL, UNIT_MDU, 7'b1000000);
        set_pkt(1, 32'h1c000008, 2'b11, 32'h02bffc41, 32'h03a00149, 2'b00, 8'h00);  // addi.w, ori
        set_slot(1, 0, 2, 0, 1, 2'b11, 2'b10, 32'hffffffff, 32'hffffffff, ALU_ADD, UNIT_ALU,
                 7'b1000000);
        set_slot(1, 1, 10, 0, 9, 2'b11, 2'b10, 32'h800, 32'hfffff800, ALU_OR, UNIT_ALU,
                 7'b1000000);
        set_pkt(2, 32'h1c000010, 2'b11, 32'h0040fd8b, 32'h1500002d, 2'b00, 8'h00);  // slli.w, lu12i.w
        set_slot(2, 0, 12, 0, 11, 2'b11, 2'b10, 32'h1f, 32'h3f, ALU_SLL, UNIT_ALU, 7'b1000000);
        set_slot(2, 1, 0, 0, 13, 2'b01, 2'b01, 32'hfff80001, 32'h0, ALU_LUI, UNIT_ALU,
                 7'b1000000);
        set_pkt(3, 32'h1c000018, 2'b11, 32'h28bfe1ee, 32'h29804230, 2'b00, 8'h00);  // ld.w, st.w
        set_slot(3, 0, 15, 0, 14, 2'b01, 2'b00, 32'hff8, 32'hfffffff8, ALU_ADD, UNIT_LSU,
                 7'b1010000);
        set_slot(3, 1, 17, 16, 0, 2'b11, 2'b00, 32'h10, 32'h10, ALU_ADD, UNIT_LSU, 7'b0001000);
        set_pkt(4, 32'h1c000020, 2'b11, 32'h5bfffe53, 32'h57fffbff, 2'b10, 8'h00);  // beq, bl
        set_slot(4, 0, 18, 19, 0, 2'b11, 2'b00, 32'hfff, 32'hfffffffc, ALU_NONE, UNIT_BRANCH,
                 7'b0100000);
        set_slot(4, 1, 0, 0, 1, 2'b00, 2'b00, 32'hffe, 32'hfffffff8, ALU_NONE, UNIT_BRANCH,
                 7'b1100000);
        set_pkt(5, 32'h1c000028, 2'b01, 32'h4c001281, 32'h5c0402b6, 2'b01, 8'h50);  // jirl, bne
        set_slot(5, 0, 20, 0, 1, 2'b01, 2'b00, 32'h4, 32'h10, ALU_NONE, UNIT_BRANCH,
                 7'b1100000);
        set_slot(5, 1, 21, 22, 0, 2'b11, 2'b00, 32'h100, 32'h400, ALU_NONE, UNIT_BRANCH,
                 7'b0100000);
        set_pkt(6, 32'h1c000030, 2'b10, 32'h002a0000, 32'h002b0000, 2'b00, 8'h20);  // break, syscall
        set_slot(6, 0, 0, 0, 0, 2'b00, 2'b00, 32'ha80, 32'hfffffa80, ALU_NONE, UNIT_ALU,
                 7'b0000100);
        set_slot(6, 1, 0, 0, 0, 2'b00, 2'b00, 32'hac0, 32'hfffffac0, ALU_NONE, UNIT_ALU,
                 7'b0000010);
        set_pkt(7, 32'h1c000038, 2'b11, 32'hffffffff, 32'h00000000, 2'b00, 8'h00);  // undefined
        set_slot(7, 0, 0, 0, 0, 2'b00, 2'b00, 32'hfff, 32'hffffffff, ALU_NONE, UNIT_ALU,
                 7'b0000001);
        set_slot(7, 1, 0, 0, 0, 2'b00, 2'b00, 32'h0, 32'h0, ALU_NONE, UNIT_ALU, 7'b0000001);
        set_pkt(8, 32'h1c000040, 2'b11, 32'h00111062, 32'h0015f7df, 2'b11, 8'h00);  // sub.w, xor
        set_slot(8, 0, 3, 4, 2, 2'b11, 2'b00, 32'h444, 32'h444, ALU_SUB, UNIT_ALU, 7'b1000000);
        set_slot(8, 1, 30, 29, 31, 2'b11, 2'b00, 32'h57d, 32'h57d, ALU_XOR, UNIT_ALU,
                 7'b1000000);
        set_pkt(9, 32'h1c000048, 2'b11, 32'h00149cc5, 32'h00152928, 2'b00, 8'h00);  // and, or
        set_slot(9, 0, 6, 7, 5, 2'b11, 2'b00, 32'h527, 32'h527, ALU_AND, UNIT_ALU, 7'b1000000);
        set_slot(9, 1, 9, 10, 8, 2'b11, 2'b00, 32'h54a, 32'h54a, ALU_OR, UNIT_ALU, 7'b1000000);
        set_pkt(10, 32'h1c000050, 2'b11, 32'h00126b9b, 32'h142468a4, 2'b00, 8'h00);  // slt, lu12i.w
        set_slot(10, 0, 28, 26, 27, 2'b11, 2'b00, 32'h49a, 32'h49a, ALU_SLT, UNIT_ALU,
                 7'b1000000);
        set_slot(10, 1, 0, 0, 4, 2'b01, 2'b01, 32'h00012345, 32'hfffff91a, ALU_LUI, UNIT_ALU,
                 7'b1000000);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure, one lfsr step per bit
    always @(negedge clk) begin
        lfsr      = lfsr_step(lfsr);
        out_ready = lfsr[0];
    end

    initial begin
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        arst_n    = 1'b0;
        lfsr      = 32'hb275;
        timed_out = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            in_valid = 1'b1;
            in_pkt   = stim[t];
            waited   = 0;
            while (!in_ready && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!in_ready) begin
                $display("timeout: the stage never took packet %0d", t);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);  // accepted on the rising edge in between
            end
        end
        in_valid = 1'b0;

        waited = 0;
        while (!timed_out && n_checked < NUM_TESTS && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!timed_out && n_checked < NUM_TESTS) begin
            $display("timeout: only %0d of %0d packets came out", n_checked, NUM_TESTS);
            timed_out = 1'b1;
        end
        repeat (4) @(negedge clk);  // catch stray output packets

        $display("%0d of %0d packets checked, %0d errors", n_checked, NUM_TESTS, n_failed);
        if (n_failed == 0 && !timed_out && n_checked == NUM_TESTS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/basic_decoder.sv
rtl/decoder.sv
rtl/fetch_queue.sv
rtl/decode_stage.sv
tb/decode_checker.sv
tb/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
